/* list.f */
+incdir+hdl
+incdir+testbench
hdl/cpu_pkg.sv
hdl/fetch_control.sv
hdl/station_credits.sv
hdl/instruction_decode.sv
hdl/register_tags.sv
hdl/station_pool.sv
hdl/cpu_top.sv
testbench/cpu_tb.sv

/* run.sh */
#!/bin/bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f list.f -o cpu_sim
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

/* testbench/cpu_tb_model.svh */
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] random_bits(input int count);
    logic [31:0] bits;
    logic feedback;
    bits = '0;
    for (int i = 0; i < count; i++) begin
        feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        bits = {bits[30:0], feedback};
    end
    return bits;
endfunction

function automatic logic [31:0] op_word(input logic [6:0] funct7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, `CPU_OPCODE_OP};
endfunction

function automatic logic [31:0] op_imm_word(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] funct3, input logic [4:0] rd);
    return {imm, rs1, funct3, rd, `CPU_OPCODE_OP_IMM};
endfunction

function automatic logic [31:0] branch_word(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] funct3);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], `CPU_OPCODE_BRANCH};
endfunction

function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `CPU_OPCODE_JAL};
endfunction

task automatic build_program(input int number);
    int f3s [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
    int rs1s [12] = '{1, 1, 1, 1, 2, 1, 1, 2, 1, 2, 2, 1}; // Even entries are taken
    int rs2s [12] = '{3, 2, 2, 3, 1, 2, 2, 1, 2, 1, 1, 2};
    int op_f3s [10] = '{0, 5, 0, 1, 4, 5, 6, 7, 2, 3}; // add sra sub sll xor srl or and slt sltu
    logic [11:0] imm;
    code = {};
    if (number == 0) begin
        for (int r = 1; r <= 4; r++) begin
            code.push_back(op_imm_word(r == 4 ? {1'b1, 11'(random_bits(11))}
                : 12'(random_bits(12)), 5'd0, 3'd0, 5'(r)));
        end
        for (int k = 0; k < 9; k++) begin
            imm = (k == 1 || k == 5) ? 12'(random_bits(5)) : 12'(random_bits(12));
            if (k == 8) begin
                imm = {7'b0100000, 4'(random_bits(4)), 1'b1}; // srai on negative x4
            end
            code.push_back(op_imm_word(imm, 5'(k == 8 ? 4 : 1 + random_bits(2)),
                3'(k == 8 ? 5 : k), 5'(5 + k)));
        end
    end else if (number == 1) begin
        for (int r = 1; r <= 3; r++) begin
            imm = {1'b1, 10'(random_bits(10)), 1'b1}; // Negative and odd
            code.push_back(op_imm_word(imm, 5'd0, 3'd0, 5'(r)));
        end
        for (int k = 0; k < 10; k++) begin
            code.push_back(op_word((k == 1 || k == 2) ? 7'b0100000 : 7'b0,
                5'(1 + (k + 1) % 3), 5'(k == 0 ? 1 : 3 + k), 3'(op_f3s[k]), 5'(4 + k)));
        end
    end else begin
        code.push_back(op_imm_word(12'd5, 5'd0, 3'd0, 5'd1));
        code.push_back(op_imm_word(-12'sd3, 5'd0, 3'd0, 5'd2));
        code.push_back(op_imm_word(12'd5, 5'd0, 3'd0, 5'd3));
        for (int k = 0; k < 12; k++) begin
            code.push_back(branch_word(13'd8, 5'(rs2s[k]), 5'(rs1s[k]), 3'(f3s[k])));
            code.push_back(op_imm_word(12'(k + 1), 5'd0, 3'd0, 5'(4 + k)));
        end
        code.push_back(jal_word(5'd16, 21'd8));
        code.push_back(op_imm_word(12'd1, 5'd0, 3'd0, 5'd17)); // Skipped
        code.push_back(op_imm_word(12'd1, 5'd16, 3'd0, 5'd18));
    end
    code.push_back(jal_word(5'd0, 21'd0));
    for (int i = 0; i < MEMORY_WORDS; i++) begin
        program_memory[i] = i < code.size() ? code[i] : {i[24:0], 7'h0b};
    end
endtask

task automatic record_write(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 0) begin
        model_registers[rd] = value;
        expected_value[rd] = value;
        expected_set[rd] = 1'b1;
        expected_count++;
    end
endtask

// In-order reference, one instruction per step
task automatic run_model();
    logic [31:0] pc;
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    logic taken;
    for (int r = 0; r < 32; r++) begin
        model_registers[r] = '0;
        expected_set[r] = 1'b0;
    end
    trace = {};
    expected_count = 0;
    pc = '0;
    for (int step = 0; step < 1000; step++) begin
        word = program_memory[pc[9:2]];
        trace.push_back(pc);
        if (word == jal_word(5'd0, 21'd0)) begin
            break;
        end
        a = model_registers[word[19:15]];
        b = word[6:0] == `CPU_OPCODE_OP_IMM ? {{20{word[31]}}, word[31:20]}
            : model_registers[word[24:20]];
        case (word[6:0])
            `CPU_OPCODE_OP_IMM, `CPU_OPCODE_OP: begin
                case (word[14:12])
                    3'd0: result = (word[5] && word[30]) ? a - b : a + b;
                    3'd1: result = a << b[4:0];
                    3'd2: result = {31'b0, $signed(a) < $signed(b)};
                    3'd3: result = {31'b0, a < b};
                    3'd4: result = a ^ b;
                    3'd5: begin
                        if (word[30]) begin
                            result = $signed(a) >>> b[4:0];
                        end else begin
                            result = a >> b[4:0];
                        end
                    end
                    3'd6: result = a | b;
                    default: result = a & b;
                endcase
                record_write(word[11:7], result);
                pc += 4;
            end
            `CPU_OPCODE_BRANCH: begin
                case (word[14:12])
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                pc += taken ? {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0} : 4;
            end
            `CPU_OPCODE_JAL: begin
                record_write(word[11:7], pc + 4);
                pc += {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
            end
            default: pc += 4;
        endcase
    end
endtask

`endif

/* testbench/cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module cpu_tb;
    localparam int MEMORY_WORDS = 256;
    localparam int PROGRAM_COUNT = 3;
    localparam int TIMEOUT_FACTOR = 24; // Cycles allowed per executed instruction

    logic clock;
    logic reset;
    logic memory_enable;
    logic [31:0] memory_address;
    logic [31:0] memory_data_in = '0;
    logic memory_ready = 1'b0;
    logic writeback_valid;
    logic [4:0] writeback_register;
    logic [31:0] writeback_value;

    logic [31:0] lfsr_state = 32'hba51;
    logic [31:0] program_memory [MEMORY_WORDS];
    logic [31:0] code [$];
    logic [31:0] trace [$]; // Expected accepted fetch addresses
    logic [31:0] model_registers [32];
    logic [31:0] expected_value [32];
    logic expected_set [32];
    logic written [32];
    int expected_count;
    int fetch_index;
    int writeback_count;
    int total_writebacks = 0;
    int error_count = 0;
    int timeout_count = 0;
    int ready_delay = 0;
    bit checking = 0;
    logic previous_pending = 1'b0;
    logic [31:0] previous_address;

    `include "cpu_tb_model.svh"

    cpu_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic report_mismatch(input string message);
        error_count++;
        $display("Fail at %0t: %s", $time, message);
    endtask

    // Memory answers after 0 to 3 idle cycles
    always @(posedge clock) begin
        #1;
        if (!memory_enable || memory_ready) begin
            memory_ready = 1'b0;
            ready_delay = random_bits(2);
        end else begin
            if (ready_delay == 0) begin
                memory_ready = 1'b1;
                memory_data_in = program_memory[memory_address[9:2]];
            end else begin
                ready_delay--;
            end
        end
    end

    always @(negedge clock) begin
        if (reset) begin
            assert (!memory_enable) else report_mismatch("memory_enable high in reset");
        end else if (checking) begin
            if (previous_pending) begin
                assert (memory_enable && memory_address == previous_address)
                    else report_mismatch($sformatf("request %h dropped early", previous_address));
            end
            if (memory_enable && memory_ready) begin
                assert (memory_address == trace[fetch_index < trace.size() ? fetch_index
                    : trace.size() - 1]) else report_mismatch(
                    $sformatf("fetch %0d went to %h", fetch_index, memory_address));
                fetch_index++;
            end
            if (writeback_valid) begin
                assert (expected_set[writeback_register] && !written[writeback_register])
                    else report_mismatch($sformatf("stray write-back to x%0d",
                    writeback_register));
                assert (writeback_value == expected_value[writeback_register])
                    else report_mismatch($sformatf("x%0d got %h, expected %h",
                    writeback_register, writeback_value, expected_value[writeback_register]));
                written[writeback_register] = 1'b1;
                writeback_count++;
                total_writebacks++;
            end
            previous_pending = memory_enable && !memory_ready;
            previous_address = memory_address;
        end
    end

    initial begin
        int cycles;
        int limit;
        bit done;
        reset = 1'b1;
        done = 1'b1;
        for (int number = 0; number < PROGRAM_COUNT && done; number++) begin
            if (number > 0) begin
                @(posedge clock);
                #1 reset = 1'b1;
            end
            build_program(number);
            run_model();
            repeat (5) @(posedge clock);
            #1;
            for (int r = 0; r < 32; r++) begin
                written[r] = 1'b0;
            end
            fetch_index = 0;
            writeback_count = 0;
            previous_pending = 1'b0;
            reset = 1'b0;
            checking = 1;
            limit = TIMEOUT_FACTOR * trace.size() + 20;
            cycles = 0;
            done = 1'b0;
            while (!done && cycles < limit) begin
                @(posedge clock);
                cycles++;
                done = fetch_index >= trace.size() && writeback_count == expected_count;
            end
            if (!done) begin
                timeout_count++;
                $display("Timeout: program %0d stalled after %0d cycles", number, cycles);
            end else begin
                repeat (10) @(posedge clock); // Catch late wrong-path write-backs
            end
            checking = 0;
        end
        $display("Summary: %0d errors, %0d timeouts, %0d write-backs checked",
            error_count, timeout_count, total_writebacks);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
    input  wire                 clock,
    input  wire                 reset,
    output logic                memory_enable,
    output cpu_pkg::word_t      memory_address,
    input  wire cpu_pkg::word_t memory_data_in,
    input  wire                 memory_ready,
    output logic                writeback_valid,
    output cpu_pkg::reg_index_t writeback_register,
    output cpu_pkg::word_t      writeback_value
);
    import cpu_pkg::*;

    logic instruction_valid;
    word_t instruction;
    word_t instruction_pc;
    logic instruction_taken;
    logic redirect;
    word_t redirect_pc;
    logic credit_available;
    logic issue;
    logic credit_return;
    alu_op_t issue_op;
    logic operand_ready_1;
    logic operand_ready_2;
    word_t operand_value_1;
    word_t operand_value_2;
    station_tag_t operand_tag_1;
    station_tag_t operand_tag_2;
    reg_index_t read_index_1;
    reg_index_t read_index_2;
    logic read_ready_1;
    logic read_ready_2;
    word_t read_value_1;
    word_t read_value_2;
    station_tag_t read_tag_1;
    station_tag_t read_tag_2;
    logic destination_busy;
    logic rename_valid;
    reg_index_t rename_index;
    station_tag_t issue_tag;
    logic link_valid;
    reg_index_t link_index;
    word_t link_value;
    logic result_valid;
    station_tag_t result_tag;
    word_t result_value;

    fetch_control fetch (.*);
    station_credits credits (.*);
    instruction_decode decode (.*);
    register_tags registers (.*);
    station_pool pool (.*);

endmodule

`default_nettype wire

/* hdl/station_pool.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module station_pool (
    input  wire                        clock,
    input  wire                        reset,
    input  wire                        issue,
    input  wire cpu_pkg::alu_op_t      issue_op,
    input  wire                        operand_ready_1,
    input  wire cpu_pkg::word_t        operand_value_1,
    input  wire cpu_pkg::station_tag_t operand_tag_1,
    input  wire                        operand_ready_2,
    input  wire cpu_pkg::word_t        operand_value_2,
    input  wire cpu_pkg::station_tag_t operand_tag_2,
    output cpu_pkg::station_tag_t      issue_tag,
    output logic                       result_valid,
    output cpu_pkg::station_tag_t      result_tag,
    output cpu_pkg::word_t             result_value,
    output logic                       credit_return
);
    import cpu_pkg::*;

    logic occupied [`CPU_STATION_COUNT];
    alu_op_t operation [`CPU_STATION_COUNT];
    logic ready_1 [`CPU_STATION_COUNT];
    logic ready_2 [`CPU_STATION_COUNT];
    station_tag_t tag_1 [`CPU_STATION_COUNT];
    station_tag_t tag_2 [`CPU_STATION_COUNT];
    word_t value_1 [`CPU_STATION_COUNT];
    word_t value_2 [`CPU_STATION_COUNT];
    logic capture_1 [`CPU_STATION_COUNT];
    logic capture_2 [`CPU_STATION_COUNT];

    function automatic word_t alu(alu_op_t op, word_t a, word_t b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_or:   return a | b;
            alu_and:  return a & b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return word_t'($signed(a) >>> b[4:0]);
            alu_sltu: return word_t'(a < b);
            default:  return word_t'($signed(a) < $signed(b));
        endcase
    endfunction

    // Downward scan leaves the lowest index selected
    always_comb begin
        issue_tag = '0;
        result_valid = 1'b0;
        result_tag = '0;
        for (int i = `CPU_STATION_COUNT - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                issue_tag = station_tag_t'(i);
            end
            if (occupied[i] && ready_1[i] && ready_2[i]) begin
                result_valid = 1'b1;
                result_tag = station_tag_t'(i);
            end
        end
        for (int i = 0; i < `CPU_STATION_COUNT; i++) begin
            capture_1[i] = occupied[i] && !ready_1[i] && result_valid_tag(tag_1[i]);
            capture_2[i] = occupied[i] && !ready_2[i] && result_valid_tag(tag_2[i]);
        end
        result_value = alu(operation[result_tag], value_1[result_tag], value_2[result_tag]);
    end

    function automatic logic result_valid_tag(station_tag_t tag);
        return result_valid && tag == result_tag;
    endfunction

    assign credit_return = result_valid;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CPU_STATION_COUNT; i++) begin
                occupied[i] <= 1'b0;
                ready_1[i] <= 1'b0;
                ready_2[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `CPU_STATION_COUNT; i++) begin
                if (capture_1[i]) begin
                    ready_1[i] <= 1'b1;
                end
                if (capture_2[i]) begin
                    ready_2[i] <= 1'b1;
                end
            end
            if (result_valid) begin
                occupied[result_tag] <= 1'b0; // Frees as it broadcasts
            end
            if (issue) begin
                occupied[issue_tag] <= 1'b1;
                ready_1[issue_tag] <= operand_ready_1;
                ready_2[issue_tag] <= operand_ready_2;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `CPU_STATION_COUNT; i++) begin
            if (capture_1[i]) begin
                value_1[i] <= result_value;
            end
            if (capture_2[i]) begin
                value_2[i] <= result_value;
            end
        end
        if (issue) begin
            operation[issue_tag] <= issue_op;
            tag_1[issue_tag] <= operand_tag_1;
            tag_2[issue_tag] <= operand_tag_2;
            value_1[issue_tag] <= operand_value_1;
            value_2[issue_tag] <= operand_value_2;
        end
    end

    // Credit count and occupancy agree
    assert property (@(posedge clock) disable iff (reset) issue |-> !occupied[issue_tag]);

endmodule

`default_nettype wire

/* hdl/register_tags.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module register_tags (
    input  wire                        clock,
    input  wire                        reset,
    input  wire cpu_pkg::reg_index_t   read_index_1,
    input  wire cpu_pkg::reg_index_t   read_index_2,
    output logic                       read_ready_1,
    output logic                       read_ready_2,
    output cpu_pkg::word_t             read_value_1,
    output cpu_pkg::word_t             read_value_2,
    output cpu_pkg::station_tag_t      read_tag_1,
    output cpu_pkg::station_tag_t      read_tag_2,
    output logic                       destination_busy,
    input  wire                        rename_valid,
    input  wire cpu_pkg::reg_index_t   rename_index,
    input  wire cpu_pkg::station_tag_t issue_tag,
    input  wire                        link_valid,
    input  wire cpu_pkg::reg_index_t   link_index,
    input  wire cpu_pkg::word_t        link_value,
    input  wire                        result_valid,
    input  wire cpu_pkg::station_tag_t result_tag,
    input  wire cpu_pkg::word_t        result_value,
    output logic                       writeback_valid,
    output cpu_pkg::reg_index_t        writeback_register,
    output cpu_pkg::word_t             writeback_value
);
    import cpu_pkg::*;

    logic busy [1:`CPU_REG_COUNT];
    station_tag_t tags [1:`CPU_REG_COUNT];
    word_t values [1:`CPU_REG_COUNT];
    logic result_hit;
    reg_index_t result_index;

    // Returns {ready, tag, value}
    function automatic logic [`CPU_XLEN + `CPU_TAG_WIDTH:0] lookup(reg_index_t index);
        if (index == '0) begin
            return {1'b1, {`CPU_TAG_WIDTH{1'b0}}, {`CPU_XLEN{1'b0}}};
        end
        if (busy[index] && !(result_valid && result_tag == tags[index])) begin
            return {1'b0, tags[index], values[index]};
        end
        return {1'b1, tags[index], busy[index] ? result_value : values[index]}; // Bus bypass
    endfunction

    always_comb begin
        {read_ready_1, read_tag_1, read_value_1} = lookup(read_index_1);
        {read_ready_2, read_tag_2, read_value_2} = lookup(read_index_2);
    end

    // A link write needs the write-back port to itself
    assign destination_busy = result_valid || (rename_index != '0 && busy[rename_index]);

    always_comb begin
        result_hit = 1'b0;
        result_index = '0;
        for (int i = 1; i <= `CPU_REG_COUNT; i++) begin
            if (busy[i] && result_valid && tags[i] == result_tag) begin
                result_hit = 1'b1;
                result_index = reg_index_t'(i);
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i <= `CPU_REG_COUNT; i++) begin
                busy[i] <= 1'b0;
                tags[i] <= '0;
            end
            writeback_valid <= 1'b0;
        end else begin
            if (result_hit) begin
                busy[result_index] <= 1'b0;
            end
            if (rename_valid) begin
                busy[rename_index] <= 1'b1; // Wins over a same-cycle clear
                tags[rename_index] <= issue_tag;
            end
            writeback_valid <= result_hit || link_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (result_hit) begin
            values[result_index] <= result_value;
        end
        if (link_valid) begin
            values[link_index] <= link_value;
        end
        writeback_register <= link_valid ? link_index : result_index;
        writeback_value <= link_valid ? link_value : result_value;
    end

endmodule

`default_nettype wire

/* hdl/instruction_decode.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module instruction_decode (
    input  wire                        instruction_valid,
    input  wire cpu_pkg::word_t        instruction,
    input  wire cpu_pkg::word_t        instruction_pc,
    output logic                       instruction_taken,
    input  wire                        credit_available,
    output logic                       issue,
    output cpu_pkg::alu_op_t           issue_op,
    output logic                       operand_ready_1,
    output cpu_pkg::word_t             operand_value_1,
    output cpu_pkg::station_tag_t      operand_tag_1,
    output logic                       operand_ready_2,
    output cpu_pkg::word_t             operand_value_2,
    output cpu_pkg::station_tag_t      operand_tag_2,
    output cpu_pkg::reg_index_t        read_index_1,
    output cpu_pkg::reg_index_t        read_index_2,
    input  wire                        read_ready_1,
    input  wire                        read_ready_2,
    input  wire cpu_pkg::word_t        read_value_1,
    input  wire cpu_pkg::word_t        read_value_2,
    input  wire cpu_pkg::station_tag_t read_tag_1,
    input  wire cpu_pkg::station_tag_t read_tag_2,
    input  wire                        destination_busy,
    output logic                       rename_valid,
    output cpu_pkg::reg_index_t        rename_index,
    output logic                       redirect,
    output cpu_pkg::word_t             redirect_pc,
    output logic                       link_valid,
    output cpu_pkg::reg_index_t        link_index,
    output cpu_pkg::word_t             link_value
);
    import cpu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_index_t destination;
    word_t immediate_i;
    word_t immediate_b;
    word_t immediate_j;
    logic is_op_imm;
    logic is_alu;
    logic is_branch;
    logic is_jal;
    logic branch_taken;
    logic branch_go;
    logic jal_go;

    assign opcode = instruction[`CPU_OPCODE_RANGE];
    assign funct3 = instruction[`CPU_FUNCT3_RANGE];
    assign funct7 = instruction[`CPU_FUNCT7_RANGE];
    assign destination = instruction[11:7];
    assign read_index_1 = instruction[19:15];
    assign read_index_2 = instruction[24:20];

    assign immediate_i = word_t'($signed(instruction[31:20]));
    assign immediate_b = word_t'($signed({instruction[31], instruction[7],
        instruction[30:25], instruction[11:8], 1'b0}));
    assign immediate_j = word_t'($signed({instruction[31], instruction[19:12],
        instruction[20], instruction[30:21], 1'b0}));

    assign is_op_imm = opcode == `CPU_OPCODE_OP_IMM;
    assign is_alu = is_op_imm || opcode == `CPU_OPCODE_OP;
    assign is_branch = opcode == `CPU_OPCODE_BRANCH;
    assign is_jal = opcode == `CPU_OPCODE_JAL;

    always_comb begin
        case (funct3)
            3'b000:  issue_op = (!is_op_imm && funct7[5]) ? alu_sub : alu_add;
            3'b001:  issue_op = alu_sll;
            3'b010:  issue_op = alu_slt;
            3'b011:  issue_op = alu_sltu;
            3'b100:  issue_op = alu_xor;
            3'b101:  issue_op = funct7[5] ? alu_sra : alu_srl; // Also srai
            3'b110:  issue_op = alu_or;
            default: issue_op = alu_and;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  branch_taken = read_value_1 == read_value_2;
            3'b001:  branch_taken = read_value_1 != read_value_2;
            3'b100:  branch_taken = $signed(read_value_1) < $signed(read_value_2);
            3'b101:  branch_taken = $signed(read_value_1) >= $signed(read_value_2);
            3'b110:  branch_taken = read_value_1 < read_value_2;
            3'b111:  branch_taken = read_value_1 >= read_value_2;
            default: branch_taken = 1'b0;
        endcase
    end

    assign operand_ready_1 = read_ready_1;
    assign operand_value_1 = read_value_1;
    assign operand_tag_1 = read_tag_1;
    assign operand_ready_2 = is_op_imm || read_ready_2;
    assign operand_value_2 = is_op_imm ? immediate_i : read_value_2;
    assign operand_tag_2 = read_tag_2;

    assign issue = instruction_valid && is_alu && credit_available;
    assign rename_valid = issue && destination != '0;
    assign rename_index = destination;

    // Branches compare settled values only
    assign branch_go = instruction_valid && is_branch && read_ready_1 && read_ready_2;
    assign jal_go = instruction_valid && is_jal && !destination_busy;

    assign redirect = (branch_go && branch_taken) || jal_go;
    assign redirect_pc = instruction_pc + (is_jal ? immediate_j : immediate_b);

    assign link_valid = jal_go && destination != '0;
    assign link_index = destination;
    assign link_value = instruction_pc + word_t'(4);

    assign instruction_taken = issue || branch_go || jal_go
        || (instruction_valid && !is_alu && !is_branch && !is_jal); // Unknown, dropped

endmodule

`default_nettype wire

/* hdl/station_credits.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defs.svh"

module station_credits (
    input  wire  clock,
    input  wire  reset,
    input  wire  issue,
    input  wire  credit_return,
    output logic credit_available
);
    localparam int CREDIT_WIDTH = $clog2(`CPU_STATION_COUNT + 1);

    logic [CREDIT_WIDTH - 1:0] credits; // Free stations

    assign credit_available = credits != '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credits <= CREDIT_WIDTH'(`CPU_STATION_COUNT);
        end else if (issue != credit_return) begin
            credits <= issue ? credits - 1'b1 : credits + 1'b1;
        end
    end

    // Decode never issues without a free station
    assert property (@(posedge clock) disable iff (reset) issue |-> credits != '0);

    // The pool never frees more stations than it holds
    assert property (@(posedge clock) disable iff (reset)
        credit_return && !issue |-> credits < `CPU_STATION_COUNT);

endmodule

`default_nettype wire

/* hdl/fetch_control.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_control (
    input  wire                 clock,
    input  wire                 reset,
    output logic                memory_enable,
    output cpu_pkg::word_t      memory_address,
    input  wire cpu_pkg::word_t memory_data_in,
    input  wire                 memory_ready,
    output logic                instruction_valid,
    output cpu_pkg::word_t      instruction,
    output cpu_pkg::word_t      instruction_pc,
    input  wire                 instruction_taken,
    input  wire                 redirect,
    input  wire cpu_pkg::word_t redirect_pc
);
    import cpu_pkg::*;

    fetch_state_t state;
    word_t fetch_pc; // Address of the next request
    logic accept;

    assign instruction_valid = state == fetch_held;
    assign accept = state == fetch_wait && memory_ready && !redirect;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= fetch_idle;
            fetch_pc <= '0;
            memory_enable <= 1'b0;
            memory_address <= '0;
        end else begin
            case (state)
                fetch_idle: begin
                    memory_enable <= 1'b1;
                    memory_address <= fetch_pc;
                    state <= fetch_wait;
                end
                fetch_wait: begin
                    if (redirect) begin
                        fetch_pc <= redirect_pc;
                        if (memory_ready) begin
                            memory_address <= redirect_pc; // Drop it and ask again
                        end else begin
                            state <= fetch_discard;
                        end
                    end else if (memory_ready) begin
                        memory_enable <= 1'b0;
                        fetch_pc <= memory_address + word_t'(4);
                        state <= fetch_held;
                    end
                end
                fetch_held: begin
                    if (instruction_taken) begin
                        memory_enable <= 1'b1;
                        memory_address <= redirect ? redirect_pc : fetch_pc;
                        state <= fetch_wait;
                    end
                end
                fetch_discard: begin
                    if (memory_ready) begin
                        memory_address <= fetch_pc; // Stale data ignored
                        state <= fetch_wait;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            instruction <= memory_data_in;
            instruction_pc <= memory_address;
        end
    end

    // The memory only answers a pending request
    assert property (@(posedge clock) disable iff (reset) memory_ready |-> memory_enable);

endmodule

`default_nettype wire

/* hdl/cpu_pkg.sv */
`default_nettype none
`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN - 1:0] word_t;
    typedef logic [$clog2(`CPU_REG_COUNT + 1) - 1:0] reg_index_t; // Index 0 is x0
    typedef logic [`CPU_TAG_WIDTH - 1:0] station_tag_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_or,
        alu_and,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_sltu,
        alu_slt
    } alu_op_t;

    typedef enum logic [1:0] {
        fetch_idle,    // Only right after reset
        fetch_wait,
        fetch_held,
        fetch_discard  // Response belongs to a dead path
    } fetch_state_t;

endpackage

`default_nettype wire

/* hdl/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_XLEN          32
`define CPU_STATION_COUNT 4
`define CPU_TAG_WIDTH     2
`define CPU_REG_COUNT     31 // x1 to x31

`define CPU_OPCODE_RANGE  6:0
`define CPU_FUNCT3_RANGE  14:12
`define CPU_FUNCT7_RANGE  31:25

`define CPU_OPCODE_OP_IMM 7'b0010011
`define CPU_OPCODE_OP     7'b0110011
`define CPU_OPCODE_BRANCH 7'b1100011
`define CPU_OPCODE_JAL    7'b1101111

`endif
